// ==== common/heap_params.svh ====
/*
  Size macros for the array heap. Included by the packages and by every
  module that needs a width, so one edit here resizes the whole heap.
*/
`ifndef HEAP_PARAMS_SVH
`define HEAP_PARAMS_SVH

// ----------------------------------------------------------------------
// Array pool geometry
// ----------------------------------------------------------------------
`define HEAP_ADDRESS_BITS 3                      // Bits in an array number, 8 arrays

`define HEAP_INDEX_BITS   3                      // Bits in an index, 8 elements per array

// ----------------------------------------------------------------------
// Data path widths
// ----------------------------------------------------------------------
`define HEAP_DATA_BITS    16                     // Width of one element

`define HEAP_ACTION_BITS  8                      // Width of the action code port

`endif

// ==== common/heapOpPkg.sv ====
/*
  Types of the action interface: the opcodes a user may present on the
  action port and the error codes returned on the error port.
*/
`include "heap_params.svh"

package heapOpPkg;

  // --------------------------------------------------------------------
  // Action codes in the fixed heap action numbering
  // --------------------------------------------------------------------
  typedef enum logic [`HEAP_ACTION_BITS-1:0] {
    idle      = 0,                               // No action
    clearHeap = 1,                               // Forget every array
    write     = 2,                               // Store an element
    read      = 3,                               // Fetch an element
    size      = 4,                               // Current array size
    push      = 14,                              // Append at the end
    pop       = 15,                              // Remove from the end
    alloc     = 18,                              // Get a new array
    free      = 19,                              // Give an array back
    add       = 20,                              // New value of element plus in
    subtract  = 22                               // New value of element minus in
  } opcode_e;

  // --------------------------------------------------------------------
  // Refusal reasons in checking order after none
  // --------------------------------------------------------------------
  typedef enum logic [2:0] {
    none,                                        // Action accepted
    notIssued,                                   // Array number never handed out
    freed,                                       // Array handed out then freed
    outOfBounds,                                 // Index at or past size
    full,                                        // Push onto full array
    empty,                                       // Pop from empty array
    outOfMemory                                  // No array left to allocate
  } heapError_e;

endpackage

// ==== common/heapStorePkg.sv ====
/*
  Types of the stored data: array numbers, element indices, array sizes
  and elements, plus the pool constants derived from the size macros.
*/
`include "heap_params.svh"

package heapStorePkg;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayNum_t;  // Which array
  typedef logic [`HEAP_INDEX_BITS-1:0]   index_t;     // Element within array
  typedef logic [`HEAP_INDEX_BITS:0]     size_t;      // 0 up to full capacity
  typedef logic [`HEAP_DATA_BITS-1:0]    element_t;   // One stored element

  // --------------------------------------------------------------------
  // Pool constants
  // --------------------------------------------------------------------
  localparam int unsigned arrayCount    = 1 << `HEAP_ADDRESS_BITS;  // Arrays in the pool

  localparam int unsigned arrayCapacity = 1 << `HEAP_INDEX_BITS;    // Elements per array

endpackage

// ==== heap/heapAllocator.sv ====
/*
  Decides which arrays exist. Fresh numbers come from an issue counter,
  freed numbers go onto a stack and are handed out again last-in first-out.
*/
`include "heap_params.svh"

module heapAllocator (
  input  logic                   clock,
  input  logic                   reset,
  input  heapOpPkg::opcode_e     opcode,
  input  logic                   accept,
  input  heapStorePkg::arrayNum_t array,
  output logic                   arrayIssued,
  output logic                   arrayLive,
  output logic                   canAlloc,
  output heapStorePkg::arrayNum_t grantArray
);
  import heapOpPkg::*;
  import heapStorePkg::*;

  arrayNum_t                   freeStack [arrayCount];  // Freed array numbers
  logic [`HEAP_ADDRESS_BITS:0] stackTop;                // Entries on the stack
  logic [`HEAP_ADDRESS_BITS:0] belowTop;                // Slot of the top entry
  logic [`HEAP_ADDRESS_BITS:0] issueCount;              // Next fresh array number
  logic [arrayCount-1:0]       liveBits;                // One per array
  logic                        stackEmpty;

  // ----------------------------------------------------------------------
  // Status towards the decoder
  // ----------------------------------------------------------------------
  assign stackEmpty  = (stackTop == '0);
  assign belowTop    = stackTop - 1'b1;
  assign arrayIssued = ({1'b0, array} < issueCount);      // Numbers below counter issued
  assign arrayLive   = liveBits[array];
  assign canAlloc    = !stackEmpty || (issueCount < arrayCount);

  // Reuse before issuing fresh numbers
  assign grantArray  = stackEmpty ? issueCount[`HEAP_ADDRESS_BITS-1:0]
                                  : freeStack[belowTop[`HEAP_ADDRESS_BITS-1:0]];

  // ----------------------------------------------------------------------
  // Control state
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || (accept && opcode == clearHeap)) begin  // Empty everything
      stackTop   <= '0;
      issueCount <= '0;
      liveBits   <= '0;
    end else if (accept) begin
      case (opcode)
        alloc: begin
          liveBits[grantArray] <= 1'b1;
          if (stackEmpty) issueCount <= issueCount + 1'b1;  // Fresh number
          else            stackTop   <= belowTop;           // Pop reused number
        end
        free: begin
          liveBits[array] <= 1'b0;
          stackTop        <= stackTop + 1'b1;
        end
        default: ;                                   // Data actions leave pool alone
      endcase
    end
  end

  // Stack contents, only meaningful below stackTop
  always_ff @(posedge clock) begin
    if (accept && opcode == free) begin
      freeStack[stackTop[`HEAP_ADDRESS_BITS-1:0]] <= array;
    end
  end

endmodule

// ==== heap/elementStore.sv ====
/*
  Element memory and size table. Carries out the accepted data actions
  and presents the value each action returns on storeData.
*/
`include "heap_params.svh"

module elementStore (
  input  logic                    clock,
  input  heapOpPkg::opcode_e      opcode,
  input  logic                    accept,
  input  heapStorePkg::arrayNum_t array,
  input  heapStorePkg::index_t    index,
  input  heapStorePkg::element_t  in,
  input  heapStorePkg::arrayNum_t grantArray,
  output heapStorePkg::size_t     curSize,
  output heapStorePkg::element_t  storeData
);
  import heapOpPkg::*;
  import heapStorePkg::*;

  element_t elementMem [arrayCount][arrayCapacity];  // Fixed block per array
  size_t    sizeTable  [arrayCount];                 // Current size per array

  size_t    sizeLess;                                // Size after a pop
  size_t    writeSize;                               // Size implied by a write
  index_t   pushIndex;
  index_t   popIndex;
  element_t element;                                 // Addressed element
  element_t sum;
  element_t difference;

  // ----------------------------------------------------------------------
  // Addressing and arithmetic
  // ----------------------------------------------------------------------
  assign curSize    = sizeTable[array];
  assign sizeLess   = curSize - 1'b1;
  assign writeSize  = {1'b0, index} + 1'b1;
  assign pushIndex  = curSize[`HEAP_INDEX_BITS-1:0];   // First free slot
  assign popIndex   = sizeLess[`HEAP_INDEX_BITS-1:0];  // Last used slot
  assign element    = elementMem[array][index];
  assign sum        = element + in;                    // Wraps at data width
  assign difference = element - in;

  // Value returned by each action
  always_comb begin
    case (opcode)
      write:    storeData = in;
      read:     storeData = element;
      size:     storeData = element_t'(curSize);       // Zero extended
      pop:      storeData = elementMem[array][popIndex];
      add:      storeData = sum;
      subtract: storeData = difference;
      default:  storeData = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Updates on accepted actions
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (accept) begin
      case (opcode)
        write: begin
          elementMem[array][index] <= in;
          if ({1'b0, index} >= curSize) sizeTable[array] <= writeSize;  // Grow
        end
        push: begin
          elementMem[array][pushIndex] <= in;
          sizeTable[array]             <= curSize + 1'b1;
        end
        pop:      sizeTable[array]         <= sizeLess;
        add:      elementMem[array][index] <= sum;
        subtract: elementMem[array][index] <= difference;
        alloc:    sizeTable[grantArray]    <= '0;   // New array starts empty
        default: ;                                  // Read, size, free
      endcase
    end
  end

endmodule

// ==== hw/actionDecoder.sv ====
/*
  Combinational front end. Maps the raw action code onto an opcode and
  tests it against the heap state, naming the first failing check.
*/
`include "heap_params.svh"

module actionDecoder (
  input  logic [`HEAP_ACTION_BITS-1:0] action,
  input  heapStorePkg::index_t         index,
  input  logic                         arrayIssued,
  input  logic                         arrayLive,
  input  heapStorePkg::size_t          curSize,
  input  logic                         canAlloc,
  output heapOpPkg::opcode_e           opcode,
  output logic                         accept,
  output heapOpPkg::heapError_e        errorCode
);
  import heapOpPkg::*;
  import heapStorePkg::*;

  logic needsElement;                            // Touches an existing element
  logic inBounds;
  logic hasRoom;
  logic hasData;

  // ----------------------------------------------------------------------
  // Opcode decode
  // ----------------------------------------------------------------------
  always_comb begin
    case (action)
      idle, clearHeap, write, read, size, push, pop,
      alloc, free, add, subtract: opcode = opcode_e'(action);
      default:                    opcode = idle;  // Unknown codes do nothing
    endcase
  end

  // Per-array conditions
  assign needsElement = (opcode == read) || (opcode == add) || (opcode == subtract);
  assign inBounds     = ({1'b0, index} < curSize);
  assign hasRoom      = (curSize < arrayCapacity);
  assign hasData      = (curSize != '0);

  // ----------------------------------------------------------------------
  // Legality, first failure wins
  // ----------------------------------------------------------------------
  always_comb begin
    errorCode = none;
    case (opcode)
      idle, clearHeap: ;                         // Always fine
      alloc: begin
        if (!canAlloc) errorCode = outOfMemory;
      end
      default: begin                             // Needs a live array
        if (!arrayIssued)                      errorCode = notIssued;
        else if (!arrayLive)                   errorCode = freed;
        else if (needsElement && !inBounds)    errorCode = outOfBounds;
        else if (opcode == push && !hasRoom)   errorCode = full;
        else if (opcode == pop && !hasData)    errorCode = empty;
      end
    endcase
  end

  assign accept = (opcode != idle) && (errorCode == none);

endmodule

// ==== hw/resultStage.sv ====
/*
  Output registers. Captures the result and the error of each action on
  the edge it is presented; refused and idle actions leave out alone.
*/
module resultStage (
  input  logic                    clock,
  input  logic                    reset,
  input  heapOpPkg::opcode_e      opcode,
  input  logic                    accept,
  input  heapOpPkg::heapError_e   errorCode,
  input  heapStorePkg::element_t  storeData,
  input  heapStorePkg::arrayNum_t grantArray,
  output heapStorePkg::element_t  out,
  output heapOpPkg::heapError_e   error
);
  import heapOpPkg::*;
  import heapStorePkg::*;

  // ----------------------------------------------------------------------
  // Result registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= none;
    end else if (opcode != idle) begin           // Idle holds both
      error <= errorCode;                        // None when accepted
      if (accept) begin
        case (opcode)
          alloc:           out <= element_t'(grantArray);  // New array number
          clearHeap, free: ;                               // Nothing to report
          default:         out <= storeData;
        endcase
      end
    end
  end

endmodule

// ==== hw/arrayHeap.sv ====
/*
  Array heap top level. One action per clock edge; the result and error
  of an action appear on out and error right after the edge it is given.
*/
`include "heap_params.svh"

module arrayHeap (
  input  logic                         clock,
  input  logic                         reset,
  input  logic [`HEAP_ACTION_BITS-1:0] action,
  input  heapStorePkg::arrayNum_t      array,
  input  heapStorePkg::index_t         index,
  input  heapStorePkg::element_t       in,
  output heapStorePkg::element_t       out,
  output heapOpPkg::heapError_e        error
);
  import heapOpPkg::*;
  import heapStorePkg::*;

  opcode_e    opcode;                            // Decoded action
  logic       accept;                            // Action passes every check
  heapError_e errorCode;
  logic       arrayIssued;
  logic       arrayLive;
  logic       canAlloc;
  arrayNum_t  grantArray;                        // Array an alloc would get
  size_t      curSize;
  element_t   storeData;

  // ----------------------------------------------------------------------
  // Decode and check
  // ----------------------------------------------------------------------
  actionDecoder decoder (
    .action      (action),
    .index       (index),
    .arrayIssued (arrayIssued),
    .arrayLive   (arrayLive),
    .curSize     (curSize),
    .canAlloc    (canAlloc),
    .opcode      (opcode),
    .accept      (accept),
    .errorCode   (errorCode)
  );

  // ----------------------------------------------------------------------
  // State
  // ----------------------------------------------------------------------
  heapAllocator allocator (
    .clock       (clock),
    .reset       (reset),
    .opcode      (opcode),
    .accept      (accept),
    .array       (array),
    .arrayIssued (arrayIssued),
    .arrayLive   (arrayLive),
    .canAlloc    (canAlloc),
    .grantArray  (grantArray)
  );

  elementStore store (
    .clock      (clock),
    .opcode     (opcode),
    .accept     (accept),
    .array      (array),
    .index      (index),
    .in         (in),
    .grantArray (grantArray),
    .curSize    (curSize),
    .storeData  (storeData)
  );

  // Registered outputs
  resultStage result (
    .clock      (clock),
    .reset      (reset),
    .opcode     (opcode),
    .accept     (accept),
    .errorCode  (errorCode),
    .storeData  (storeData),
    .grantArray (grantArray),
    .out        (out),
    .error      (error)
  );

endmodule

// ==== tb/arrayHeapTb.sv ====
/*
  Random-stimulus testbench for the array heap. A heap model steps on every
  rising edge beside the DUT, and out and error are compared on each falling
  edge. A memory fill and fixed sequences run before the random traffic.
*/
`include "heap_params.svh"

module arrayHeapTb;
  import heapOpPkg::*;
  import heapStorePkg::*;

  localparam int resetCycles    = 4;
  localparam int directedCycles = 256;           // Room for fill and fixed sequences
  localparam int randomActions  = 1900;
  localparam int timeoutCycles  = resetCycles + directedCycles + randomActions + 40;
  localparam logic [31:0] seed  = 32'he0252ef4;

  logic                         clock;
  logic                         reset;
  logic [`HEAP_ACTION_BITS-1:0] action;
  arrayNum_t                    array;
  index_t                       index;
  element_t                     in;
  element_t                     out;
  heapError_e                   error;

  // ----------------------------------------------------------------------
  // Model state
  // ----------------------------------------------------------------------
  logic        modelLive [arrayCount];
  int unsigned modelIssued;                      // Next fresh array number
  int unsigned modelFree [$];                    // Freed arrays, top at the back
  int unsigned modelSize [arrayCount];
  element_t    modelMem  [arrayCount][arrayCapacity];
  element_t    expOut;
  heapError_e  expError;
  logic        modelReady = 1'b0;                // Set once the first edge is seen
  logic [31:0] lfsr;
  int          cycleCount = 0;

  arrayHeap u_dut (
    .clock  (clock),
    .reset  (reset),
    .action (action),
    .array  (array),
    .index  (index),
    .in     (in),
    .out    (out),
    .error  (error)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                   // Period 4
  end

  // Fibonacci LFSR on taps 32 22 2 1 stepping once per bit
  function automatic int unsigned randomBits(input int count);
    int unsigned value;
    logic        feedback;
    value = 0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr     = {lfsr[30:0], feedback};
      value    = (value << 1) | feedback;
    end
    return value;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  // Raw action code to opcode with unknown codes idle
  function automatic opcode_e decodeCode(input logic [7:0] code);
    case (code)
      8'd1:    return clearHeap;
      8'd2:    return write;
      8'd3:    return read;
      8'd4:    return size;
      8'd14:   return push;
      8'd15:   return pop;
      8'd18:   return alloc;
      8'd19:   return free;
      8'd20:   return add;
      8'd22:   return subtract;
      default: return idle;
    endcase
  endfunction

  task automatic emptyPool();
    for (int a = 0; a < arrayCount; a++) modelLive[a] = 1'b0;
    modelIssued = 0;
    modelFree.delete();
  endtask

  task automatic modelStep(input logic [7:0] code, input arrayNum_t arr,
                           input index_t idx, input element_t data);
    opcode_e     op;
    heapError_e  err;
    int unsigned grant;
    op  = decodeCode(code);
    err = none;
    if (op == idle) return;                      // Holds out and error
    if (op == alloc) begin
      if (modelFree.size() == 0 && modelIssued == arrayCount) err = outOfMemory;
    end else if (op != clearHeap) begin
      if (arr >= modelIssued)                                  err = notIssued;
      else if (!modelLive[arr])                                err = freed;
      else if ((op == read || op == add || op == subtract) && idx >= modelSize[arr])
        err = outOfBounds;
      else if (op == push && modelSize[arr] == arrayCapacity)  err = full;
      else if (op == pop && modelSize[arr] == 0)               err = empty;
    end
    expError = err;
    if (err != none) return;                     // Refused so out holds
    case (op)
      clearHeap: emptyPool();
      alloc: begin
        if (modelFree.size() != 0) begin
          grant = modelFree.pop_back();          // Last freed comes back first
        end else begin
          grant = modelIssued;
          modelIssued++;
        end
        modelLive[grant] = 1'b1;
        modelSize[grant] = 0;
        expOut           = element_t'(grant);
      end
      free: begin
        modelLive[arr] = 1'b0;
        modelFree.push_back(arr);
      end
      write: begin
        modelMem[arr][idx] = data;
        if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;
        expOut = data;
      end
      read: expOut = modelMem[arr][idx];
      size: expOut = element_t'(modelSize[arr]);
      push: begin
        modelMem[arr][modelSize[arr]] = data;
        modelSize[arr]++;
        expOut = '0;                             // Push returns nothing
      end
      pop: begin
        modelSize[arr]--;
        expOut = modelMem[arr][modelSize[arr]];
      end
      add: begin
        modelMem[arr][idx] = modelMem[arr][idx] + data;  // Wraps at data width
        expOut             = modelMem[arr][idx];
      end
      subtract: begin
        modelMem[arr][idx] = modelMem[arr][idx] - data;
        expOut             = modelMem[arr][idx];
      end
      default: ;
    endcase
  endtask

  // ----------------------------------------------------------------------
  // Model stepping, checking and timeout
  // ----------------------------------------------------------------------
  always @(posedge clock) begin
    if (reset) begin
      emptyPool();
      expOut   = '0;
      expError = none;
    end else begin
      modelStep(action, array, index, in);       // Same inputs the DUT samples
    end
    modelReady = 1'b1;
  end

  always @(negedge clock) begin
    if (modelReady) begin                        // Outputs settled mid-cycle
      checkValue("out", 32'(out), 32'(expOut));
      checkValue("error", 32'(error), 32'(expError));
    end
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount > timeoutCycles) begin
      $display("Errors found");
      $fatal(1, "Timeout: the run did not finish within %0d cycles", timeoutCycles);
    end
  end

  // One action per cycle on the rising edge
  task automatic drive(input logic [7:0] code, input int arr, input int idx,
                       input element_t data);
    @(posedge clock);
    action <= code;
    array  <= arrayNum_t'(arr);
    index  <= index_t'(idx);
    in     <= data;
  endtask

  // Every element gets a value from its full address
  task automatic fillMemory();
    repeat (arrayCount) drive(alloc, 0, 0, '0);  // Arrays 0 to 7 in order
    for (int a = 0; a < arrayCount; a++) begin
      for (int i = 0; i < arrayCapacity; i++) begin
        drive(push, a, 0, element_t'((a * arrayCapacity + i) * 32'h9e37 + 32'h5a5a));
      end
    end
    drive(push, 5, 0, 16'h0bad);                 // Full
    drive(alloc, 0, 0, '0);                      // Out of memory
    drive(clearHeap, 0, 0, '0);
  endtask

  task automatic readWriteSequence();
    repeat (3) drive(alloc, 0, 0, '0);
    drive(write, 0, 3, 16'h1234);
    drive(read, 0, 3, '0);
    drive(size, 0, 0, '0);                       // Highest index plus one
    drive(read, 0, 4, '0);                       // Out of bounds
    drive(write, 0, 6, 16'hbeef);
    drive(size, 0, 0, '0);
    drive(add, 0, 3, 16'hffff);                  // Wraps past the top
    drive(subtract, 0, 6, 16'hbef0);             // Wraps below zero
    drive(read, 0, 3, '0);
    drive(read, 0, 6, '0);
  endtask

  task automatic stackSequence();
    for (int i = 0; i < arrayCapacity; i++) drive(push, 1, 0, element_t'(16'h0100 + i));
    drive(push, 1, 0, 16'hdead);                 // Full
    repeat (arrayCapacity) drive(pop, 1, 0, '0); // Reverse order
    drive(pop, 1, 0, '0);                        // Empty
  endtask

  task automatic reuseSequence();
    drive(free, 1, 0, '0);
    drive(free, 2, 0, '0);
    drive(alloc, 0, 0, '0);                      // Gets 2 back
    drive(alloc, 0, 0, '0);                      // Then 1
    drive(free, 0, 0, '0);
    drive(write, 0, 0, 16'h7777);                // Freed
    drive(free, 0, 0, '0);                       // Freed twice
    drive(read, 5, 0, '0);                       // Not issued
    repeat (7) drive(alloc, 0, 0, '0);           // Last one out of memory
    drive(clearHeap, 0, 0, '0);
    drive(read, 0, 0, '0);                       // Not issued after clear
    drive(alloc, 0, 0, '0);                      // Back to 0
    drive(9, 0, 0, '0);                          // Unknown code
    drive(size, 0, 0, '0);
  endtask

  // Mostly live arrays and sometimes any number
  function automatic int unsigned chooseArray();
    int unsigned start;
    int unsigned candidate;
    start = randomBits(`HEAP_ADDRESS_BITS);
    if (randomBits(2) != 0) begin
      for (int k = 0; k < arrayCount; k++) begin
        candidate = (start + k) % arrayCount;
        if (modelLive[candidate]) return candidate;
      end
    end
    return start;
  endfunction

  task automatic randomTraffic(input int count);
    int unsigned pick;
    int unsigned arr;
    int unsigned idx;
    logic [7:0]  code;
    for (int n = 0; n < count; n++) begin
      @(negedge clock);                          // Model settled before choosing
      pick = randomBits(4);
      case (pick)                                // Weighted towards alloc, write, push, pop
        0, 1, 2:  code = alloc;
        3, 4, 5:  code = write;
        6, 7, 8:  code = push;
        9, 10:    code = pop;
        11:       code = read;
        12:       code = size;
        13:       code = free;
        14:       code = randomBits(1) != 0 ? add : subtract;
        default: begin
          if (randomBits(5) == 0) code = clearHeap;  // Rare
          else                    code = 8'(5 + randomBits(3));  // Unknown code
        end
      endcase
      arr = chooseArray();
      idx = randomBits(`HEAP_INDEX_BITS);
      if (randomBits(2) != 0 && modelSize[arr] != 0) idx = idx % modelSize[arr];
      drive(code, arr, idx, element_t'(randomBits(`HEAP_DATA_BITS)));
    end
  endtask

  initial begin
    reset  = 1'b1;
    action = '0;
    array  = '0;
    index  = '0;
    in     = '0;
    lfsr   = seed;
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b0;
    fillMemory();
    readWriteSequence();
    stackSequence();
    reuseSequence();
    randomTraffic(randomActions);
    drive(idle, 0, 0, '0);
    repeat (2) @(posedge clock);                 // Last result checked
    $display("No errors");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+common
common/heapOpPkg.sv
common/heapStorePkg.sv
heap/heapAllocator.sv
heap/elementStore.sv
hw/actionDecoder.sv
hw/resultStage.sv
hw/arrayHeap.sv
tb/arrayHeapTb.sv

// ==== Makefile ====
SIM       := verilator
FLAGS     := --binary --timing -Wno-fatal
TOP       := arrayHeapTb
FILE_LIST := list.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
